//--- hdl/rv_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// rv32 instruction word and parcel types
// major opcode constants used when expanding compressed forms
//////////////////////////////////////////////////////////////////////
package rv_isa_pkg;

  // one full rv32 instruction
  typedef logic [31:0] instr_t;

  // one 16-bit parcel, the unit of rvc alignment
  typedef logic [15:0] half_t;

  // major opcode field, bits 6:0 of a 32-bit instruction
  typedef logic [6:0] opcode_t;

  // base opcodes produced by the expander
  localparam opcode_t OPCODE_LOAD   = 7'h03;
  localparam opcode_t OPCODE_OP_IMM = 7'h13;
  localparam opcode_t OPCODE_STORE  = 7'h23;
  localparam opcode_t OPCODE_OP     = 7'h33;
  localparam opcode_t OPCODE_LUI    = 7'h37;
  localparam opcode_t OPCODE_BRANCH = 7'h63;
  localparam opcode_t OPCODE_JALR   = 7'h67;
  localparam opcode_t OPCODE_JAL    = 7'h6f;

  // system opcode with funct12 = 1
  localparam instr_t INSTR_EBREAK = 32'h0010_0073;

endpackage

//--- hdl/fetch_pkg.sv
//////////////////////////////////////////////////////////////////////
// fetch side address and bus word types
// state encoding of the instruction bus read master
//////////////////////////////////////////////////////////////////////
package fetch_pkg;

  // byte address, instruction or bus
  typedef logic [31:0] addr_t;

  // data word returned by the instruction bus
  typedef logic [31:0] word_t;

  // IDLE    no bus cycle open
  // REQ     cycle open, response will be kept
  // DISCARD cycle open, response belongs to a stream dropped by a redirect
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    DISCARD
  } fetch_state_e;

endpackage

//--- hdl/ibus_fetcher.sv
//////////////////////////////////////////////////////////////////////
// instruction bus read master with a one-word response buffer
// sequential word reads, stale responses dropped after a redirect
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ibus_fetcher #(
  parameter fetch_pkg::addr_t RESET_PC = 32'h0000_0000
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_redirect,
  input  fetch_pkg::addr_t i_redirect_pc,
  output fetch_pkg::addr_t o_ibus_adr,
  output logic             o_ibus_cyc,
  input  fetch_pkg::word_t i_ibus_rdt,
  input  logic             i_ibus_ack,
  output logic             o_word_valid,
  output fetch_pkg::word_t o_word_data,
  output fetch_pkg::addr_t o_word_adr,
  input  logic             i_word_take
);
  import fetch_pkg::*;

  fetch_state_e state;
  // word address of the next sequential read
  addr_t        next_adr;
  // address held on the bus while a cycle is open
  addr_t        bus_adr;
  // response buffer towards the aligner
  logic         buf_valid;
  word_t        buf_data;
  addr_t        buf_adr;

  addr_t        redirect_adr;
  logic         start_req;
  logic         accept;

  // redirect target rounded down to its word
  assign redirect_adr = {i_redirect_pc[31:2], 2'b00};

  // open a cycle once the buffer is free or drains this edge
  assign start_req = (state == IDLE) && (i_redirect || !buf_valid || i_word_take);

  // ack of the live stream, a redirect in the same cycle kills it
  assign accept = (state == REQ) && i_ibus_ack && !i_redirect;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (start_req) begin
            state <= REQ;
          end
        end
        REQ: begin
          // cycle must run to its ack, even when redirected
          if (i_ibus_ack) begin
            state <= IDLE;
          end else if (i_redirect) begin
            state <= DISCARD;
          end
        end
        DISCARD: begin
          if (i_ibus_ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      next_adr  <= {RESET_PC[31:2], 2'b00};
      buf_valid <= 1'b0;
    end else begin
      if (i_redirect) begin
        next_adr <= redirect_adr;
      end else if (accept) begin
        next_adr <= bus_adr + 32'd4;
      end
      // redirect empties the buffer on the same edge
      if (i_redirect) begin
        buf_valid <= 1'b0;
      end else if (accept) begin
        buf_valid <= 1'b1;
      end else if (i_word_take) begin
        buf_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    // bus address latched when the cycle opens, frozen until the ack
    if (start_req) begin
      bus_adr <= i_redirect ? redirect_adr : next_adr;
    end
    if (accept) begin
      buf_data <= i_ibus_rdt;
      buf_adr  <= bus_adr;
    end
  end

  assign o_ibus_cyc   = (state == REQ) || (state == DISCARD);
  assign o_ibus_adr   = bus_adr;
  assign o_word_valid = buf_valid;
  assign o_word_data  = buf_data;
  assign o_word_adr   = buf_adr;

endmodule

//--- hdl/instr_aligner.sv
//////////////////////////////////////////////////////////////////////
// halfword aligner between fetched words and whole instructions
// keeps one leftover parcel and the pc of the next instruction
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_aligner #(
  parameter int unsigned      COMPRESSED = 1,
  parameter fetch_pkg::addr_t RESET_PC   = 32'h0000_0000
) (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic               i_redirect,
  input  fetch_pkg::addr_t   i_redirect_pc,
  input  logic               i_word_valid,
  input  fetch_pkg::word_t   i_word_data,
  input  fetch_pkg::addr_t   i_word_adr,
  output logic               o_word_take,
  output rv_isa_pkg::instr_t o_raw_instr,
  input  logic               i_is_comp,
  output logic               o_valid,
  output fetch_pkg::addr_t   o_pc,
  input  logic               i_ready
);
  import rv_isa_pkg::*;
  import fetch_pkg::*;

  addr_t pc;
  // upper half of the last taken word, not yet consumed
  logic  lo_valid;
  half_t lo_half;

  half_t parcel;
  logic  is16;
  logic  odd_start;
  logic  fire;
  addr_t pc_step;

  // first word after a redirect to an odd halfword, lower half is skipped
  assign odd_start = (COMPRESSED != 0) && pc[1] && !lo_valid;

  // parcel at the current pc
  assign parcel = lo_valid ? lo_half : i_word_data[15:0];
  assign is16   = (COMPRESSED != 0) && (parcel[1:0] != 2'b11);

  // without a leftover the pc lives in the buffered word
  assign o_pc = lo_valid ? pc : {i_word_adr[31:2], pc[1:0]};

  always_comb begin
    if (is16) begin
      o_raw_instr = {16'h0000, parcel};
    end else if (lo_valid) begin
      // straddling instruction, upper half from the next word
      o_raw_instr = {i_word_data[15:0], lo_half};
    end else begin
      o_raw_instr = i_word_data;
    end
  end

  always_comb begin
    if (lo_valid && is16) begin
      // leftover is a whole instruction, no word needed
      o_valid     = 1'b1;
      o_word_take = 1'b0;
    end else if (odd_start) begin
      // swallow the word and keep only its upper half
      o_valid     = 1'b0;
      o_word_take = i_word_valid;
    end else begin
      o_valid     = i_word_valid;
      o_word_take = i_word_valid && i_ready;
    end
  end

  assign fire = o_valid && i_ready;

  // reserved c0 forms come back with the flag low yet still take a halfword
  assign pc_step = (is16 || i_is_comp) ? 32'd2 : 32'd4;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc       <= RESET_PC;
      lo_valid <= 1'b0;
    end else if (i_redirect) begin
      pc       <= i_redirect_pc;
      lo_valid <= 1'b0;
    end else if (odd_start && i_word_valid) begin
      pc       <= o_pc;
      lo_valid <= 1'b1;
    end else if (fire) begin
      pc       <= o_pc + pc_step;
      // a 16-bit parcel flips the leftover, a 32-bit one keeps it
      lo_valid <= lo_valid ^ is16;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_word_take) begin
      lo_half <= i_word_data[31:16];
    end
  end

endmodule

//--- hdl/comp_decoder.sv
//////////////////////////////////////////////////////////////////////
// combinational rvc expander of quadrants c0 to c2 into rv32
// 32-bit and reserved encodings pass through with the flag low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module comp_decoder #(
  parameter int unsigned COMPRESSED = 1
) (
  input  rv_isa_pkg::instr_t i_instr,
  output rv_isa_pkg::instr_t o_instr,
  output logic               o_iscomp
);
  import rv_isa_pkg::*;

  generate
    if (COMPRESSED != 0) begin : g_rvc
      half_t  c;
      instr_t comp_instr;
      // instruction left as it came in
      logic   raw;

      assign c = i_instr[15:0];

      always_comb begin
        comp_instr = i_instr;
        raw        = 1'b0;
        case (c[1:0])
          //////////////////////////////////////////////////////////////////////
          // quadrant c0 with register fields in x8..x15
          //////////////////////////////////////////////////////////////////////
          2'b00: begin
            case (c[15:14])
              // c.addi4spn -> addi rd', x2, nzuimm
              2'b00: comp_instr = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                                   5'h02, 3'b000, 2'b01, c[4:2], OPCODE_OP_IMM};
              // c.lw -> lw rd', uimm(rs1')
              2'b01: comp_instr = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7],
                                   3'b010, 2'b01, c[4:2], OPCODE_LOAD};
              // c.sw -> sw rs2', uimm(rs1')
              2'b11: comp_instr = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                                   3'b010, c[11:10], c[6], 2'b00, OPCODE_STORE};
              // reserved encoding forwarded raw
              default: raw = 1'b1;
            endcase
          end

          //////////////////////////////////////////////////////////////////////
          // quadrant c1
          //////////////////////////////////////////////////////////////////////
          2'b01: begin
            case (c[15:13])
              // c.addi / c.nop -> addi rd, rd, imm
              3'b000: comp_instr = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000,
                                    c[11:7], OPCODE_OP_IMM};
              // c.jal links to x1 and c.j to x0
              // rd bit 0 is the inverse of bit 15
              3'b001, 3'b101: comp_instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                                            c[5:3], {9{c[12]}}, 4'b0000, ~c[15],
                                            OPCODE_JAL};
              // c.li -> addi rd, x0, imm
              3'b010: comp_instr = {{6{c[12]}}, c[12], c[6:2], 5'b0, 3'b000, c[11:7],
                                    OPCODE_OP_IMM};
              3'b011: begin
                if (c[11:7] == 5'h02) begin
                  // c.addi16sp -> addi x2, x2, nzimm
                  comp_instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'h02,
                                3'b000, 5'h02, OPCODE_OP_IMM};
                end else begin
                  // c.lui -> lui rd, nzimm
                  comp_instr = {{15{c[12]}}, c[6:2], c[11:7], OPCODE_LUI};
                end
              end
              3'b100: begin
                case (c[11:10])
                  // c.srli / c.srai where bit 10 selects the arithmetic shift
                  2'b00, 2'b01: comp_instr = {1'b0, c[10], 5'b0, c[6:2], 2'b01, c[9:7],
                                              3'b101, 2'b01, c[9:7], OPCODE_OP_IMM};
                  // c.andi -> andi rd', rd', imm
                  2'b10: comp_instr = {{6{c[12]}}, c[12], c[6:2], 2'b01, c[9:7], 3'b111,
                                       2'b01, c[9:7], OPCODE_OP_IMM};
                  2'b11: begin
                    // register-register ops on rd' and rs2'
                    case (c[6:5])
                      // c.sub with funct7 0100000
                      2'b00: comp_instr = {2'b01, 5'b0, 2'b01, c[4:2], 2'b01, c[9:7],
                                           3'b000, 2'b01, c[9:7], OPCODE_OP};
                      // c.xor
                      2'b01: comp_instr = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b100,
                                           2'b01, c[9:7], OPCODE_OP};
                      // c.or
                      2'b10: comp_instr = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b110,
                                           2'b01, c[9:7], OPCODE_OP};
                      // c.and
                      default: comp_instr = {7'b0, 2'b01, c[4:2], 2'b01, c[9:7], 3'b111,
                                             2'b01, c[9:7], OPCODE_OP};
                    endcase
                  end
                endcase
              end
              // c.beqz / c.bnez where bit 13 picks funct3 bit 0
              default: comp_instr = {{4{c[12]}}, c[6:5], c[2], 5'b0, 2'b01, c[9:7], 2'b00,
                                     c[13], c[11:10], c[4:3], c[12], OPCODE_BRANCH};
            endcase
          end

          //////////////////////////////////////////////////////////////////////
          // quadrant c2 with full register fields
          //////////////////////////////////////////////////////////////////////
          2'b10: begin
            case (c[15:14])
              // c.slli -> slli rd, rd, shamt
              2'b00: comp_instr = {7'b0, c[6:2], c[11:7], 3'b001, c[11:7], OPCODE_OP_IMM};
              // c.lwsp -> lw rd, uimm(x2)
              2'b01: comp_instr = {4'b0000, c[3:2], c[12], c[6:4], 2'b00, 5'h02, 3'b010,
                                   c[11:7], OPCODE_LOAD};
              2'b10: begin
                if (!c[12]) begin
                  if (c[6:2] != 5'b0) begin
                    // c.mv -> add rd, x0, rs2
                    comp_instr = {7'b0, c[6:2], 5'b0, 3'b000, c[11:7], OPCODE_OP};
                  end else begin
                    // c.jr -> jalr x0, 0(rs1)
                    comp_instr = {12'b0, c[11:7], 3'b000, 5'b0, OPCODE_JALR};
                  end
                end else if (c[6:2] != 5'b0) begin
                  // c.add -> add rd, rd, rs2
                  comp_instr = {7'b0, c[6:2], c[11:7], 3'b000, c[11:7], OPCODE_OP};
                end else if (c[11:7] == 5'b0) begin
                  comp_instr = INSTR_EBREAK;
                end else begin
                  // c.jalr -> jalr x1, 0(rs1)
                  comp_instr = {12'b0, c[11:7], 3'b000, 5'b00001, OPCODE_JALR};
                end
              end
              // c.swsp -> sw rs2, uimm(x2)
              default: comp_instr = {4'b0000, c[8:7], c[12], c[6:2], 5'h02, 3'b010,
                                     c[11:9], 2'b00, OPCODE_STORE};
            endcase
          end

          // already a 32-bit instruction
          default: raw = 1'b1;
        endcase
      end

      assign o_instr  = comp_instr;
      assign o_iscomp = !raw;
    end else begin : g_rv32
      // rv32 only so nothing is expanded
      assign o_instr  = i_instr;
      assign o_iscomp = 1'b0;
    end
  endgenerate

endmodule

//--- hdl/instr_out_reg.sv
//////////////////////////////////////////////////////////////////////
// one-entry valid/ready holding register on the consumer side
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_out_reg (
  input  logic               i_clk,
  input  logic               i_arst_n,
  input  logic               i_redirect,
  input  logic               i_valid,
  output logic               o_ready,
  input  rv_isa_pkg::instr_t i_instr,
  input  fetch_pkg::addr_t   i_pc,
  input  logic               i_iscomp,
  output logic               o_valid,
  input  logic               i_ready,
  output rv_isa_pkg::instr_t o_instr,
  output fetch_pkg::addr_t   o_pc,
  output logic               o_iscomp
);

  logic load;

  // free when empty, or when the consumer drains it on this edge
  assign o_ready = !o_valid || i_ready;
  assign load    = i_valid && o_ready;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (i_redirect) begin
      // anything not yet transferred is dropped
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  // outputs hold while valid and not ready
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_instr  <= i_instr;
      o_pc     <= i_pc;
      o_iscomp <= i_iscomp;
    end
  end

endmodule

//--- hdl/fetch_frontend_top.sv
//////////////////////////////////////////////////////////////////////
// fetch front end top, bus master to aligner to expander to output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_frontend_top #(
  parameter int unsigned      COMPRESSED = 1,
  parameter fetch_pkg::addr_t RESET_PC   = 32'h0000_0000
) (
  input  logic               i_clk,
  input  logic               i_arst_n,
  // instruction bus
  output fetch_pkg::addr_t   o_ibus_adr,
  output logic               o_ibus_cyc,
  input  fetch_pkg::word_t   i_ibus_rdt,
  input  logic               i_ibus_ack,
  // restart fetch at a halfword address
  input  logic               i_redirect,
  input  fetch_pkg::addr_t   i_redirect_pc,
  // instruction stream to the consumer
  output logic               o_valid,
  input  logic               i_ready,
  output rv_isa_pkg::instr_t o_instr,
  output fetch_pkg::addr_t   o_pc,
  output logic               o_iscomp
);
  import rv_isa_pkg::*;
  import fetch_pkg::*;

  // fetcher to aligner
  logic   word_valid;
  word_t  word_data;
  addr_t  word_adr;
  logic   word_take;
  // aligner and expander
  instr_t raw_instr;
  instr_t exp_instr;
  logic   is_comp;
  // aligner to output register
  logic   al_valid;
  addr_t  al_pc;
  logic   al_ready;

  ibus_fetcher #(
    .RESET_PC (RESET_PC)
  ) u_fetcher (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_ibus_adr    (o_ibus_adr),
    .o_ibus_cyc    (o_ibus_cyc),
    .i_ibus_rdt    (i_ibus_rdt),
    .i_ibus_ack    (i_ibus_ack),
    .o_word_valid  (word_valid),
    .o_word_data   (word_data),
    .o_word_adr    (word_adr),
    .i_word_take   (word_take)
  );

  instr_aligner #(
    .COMPRESSED (COMPRESSED),
    .RESET_PC   (RESET_PC)
  ) u_aligner (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .i_word_valid  (word_valid),
    .i_word_data   (word_data),
    .i_word_adr    (word_adr),
    .o_word_take   (word_take),
    .o_raw_instr   (raw_instr),
    .i_is_comp     (is_comp),
    .o_valid       (al_valid),
    .o_pc          (al_pc),
    .i_ready       (al_ready)
  );

  comp_decoder #(
    .COMPRESSED (COMPRESSED)
  ) u_decoder (
    .i_instr  (raw_instr),
    .o_instr  (exp_instr),
    .o_iscomp (is_comp)
  );

  instr_out_reg u_out_reg (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_redirect (i_redirect),
    .i_valid    (al_valid),
    .o_ready    (al_ready),
    .i_instr    (exp_instr),
    .i_pc       (al_pc),
    .i_iscomp   (is_comp),
    .o_valid    (o_valid),
    .i_ready    (i_ready),
    .o_instr    (o_instr),
    .o_pc       (o_pc),
    .o_iscomp   (o_iscomp)
  );

endmodule

//--- bench/rvc_ref_model.svh
//////////////////////////////////////////////////////////////////////
// rvc reference expansion built from the isa immediate layouts
// program image builders and expected stream walker
//////////////////////////////////////////////////////////////////////
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// base format encoders
function automatic instr_t enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                 logic [4:0] rd, opcode_t op);
  return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic instr_t enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3, opcode_t op);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic instr_t enc_b(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3);
  return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
endfunction

function automatic instr_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                 logic [2:0] f3, logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPCODE_OP};
endfunction

// returns {compressed flag, expanded instruction}
function automatic logic [32:0] expand_ref(half_t c);
  logic [31:0] imm;
  logic [31:0] sx6;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rdp;
  logic [4:0]  rs2p;
  logic [2:0]  f3;
  instr_t      r;
  logic        comp;
  rd   = c[11:7];
  rs2  = c[6:2];
  rdp  = {2'b01, c[9:7]};
  rs2p = {2'b01, c[4:2]};
  sx6  = {{26{c[12]}}, c[12], c[6:2]};
  comp = 1'b1;
  r    = {16'h0000, c};
  case (c[1:0])
    2'b00: begin
      // bit 13 is not decoded in c0
      case (c[15:14])
        2'b00: r = enc_i({22'b0, c[10:7], c[12:11], c[5], c[6], 2'b00}, 5'd2, 3'b000,
                         rs2p, OPCODE_OP_IMM);
        2'b01: r = enc_i({25'b0, c[5], c[12:10], c[6], 2'b00}, rdp, 3'b010, rs2p,
                         OPCODE_LOAD);
        2'b11: r = enc_s({25'b0, c[5], c[12:10], c[6], 2'b00}, rs2p, rdp, 3'b010,
                         OPCODE_STORE);
        default: comp = 1'b0;
      endcase
    end
    2'b01: begin
      case (c[15:13])
        3'b000: r = enc_i(sx6, rd, 3'b000, rd, OPCODE_OP_IMM);
        3'b001, 3'b101: begin
          imm = {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
          r = {imm[20], imm[10:1], imm[11], imm[19:12], (c[15] ? 5'd0 : 5'd1), OPCODE_JAL};
        end
        3'b010: r = enc_i(sx6, 5'd0, 3'b000, rd, OPCODE_OP_IMM);
        3'b011: begin
          if (rd == 5'd2) begin
            imm = {{22{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
            r = enc_i(imm, 5'd2, 3'b000, 5'd2, OPCODE_OP_IMM);
          end else begin
            r = {{14{c[12]}}, c[12], c[6:2], rd, OPCODE_LUI};
          end
        end
        3'b100: begin
          case (c[11:10])
            2'b00: r = enc_i({27'b0, c[6:2]}, rdp, 3'b101, rdp, OPCODE_OP_IMM);
            // arithmetic shift sets imm bit 10
            2'b01: r = enc_i({21'b0, 1'b1, 5'b0, c[6:2]}, rdp, 3'b101, rdp, OPCODE_OP_IMM);
            2'b10: r = enc_i(sx6, rdp, 3'b111, rdp, OPCODE_OP_IMM);
            default: begin
              f3 = (c[6:5] == 2'b00) ? 3'b000 : (c[6:5] == 2'b01) ? 3'b100 :
                   (c[6:5] == 2'b10) ? 3'b110 : 3'b111;
              r = enc_r((c[6:5] == 2'b00) ? 7'b0100000 : 7'b0, rs2p, rdp, f3, rdp);
            end
          endcase
        end
        default: begin
          imm = {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
          r = enc_b(imm, rdp, {2'b00, c[13]});
        end
      endcase
    end
    2'b10: begin
      case (c[15:14])
        2'b00: r = enc_i({27'b0, c[6:2]}, rd, 3'b001, rd, OPCODE_OP_IMM);
        2'b01: r = enc_i({24'b0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'b010, rd,
                         OPCODE_LOAD);
        2'b10: begin
          if (rs2 != 5'd0) r = enc_r(7'b0, rs2, c[12] ? rd : 5'd0, 3'b000, rd);
          else if (!c[12]) r = enc_i(32'd0, rd, 3'b000, 5'd0, OPCODE_JALR);
          else if (rd == 5'd0) r = INSTR_EBREAK;
          else r = enc_i(32'd0, rd, 3'b000, 5'd1, OPCODE_JALR);
        end
        default: r = enc_s({24'b0, c[8:7], c[12:9], 2'b00}, rs2, 5'd2, 3'b010, OPCODE_STORE);
      endcase
    end
    default: comp = 1'b0;
  endcase
  return {comp, r};
endfunction

// image memory access by halfword
function automatic half_t get_half(addr_t a);
  return a[1] ? mem[a[13:2]][31:16] : mem[a[13:2]][15:0];
endfunction

task automatic put_half(half_t h);
  if (wr_ptr[1]) mem[wr_ptr[13:2]][31:16] = h;
  else mem[wr_ptr[13:2]][15:0] = h;
  wr_ptr = wr_ptr + 32'd2;
endtask

task automatic put_rv32();
  logic [31:0] w;
  w = $urandom | 32'd3;
  put_half(w[15:0]);
  put_half(w[31:16]);
endtask

// random parcel from quadrant 0, 1 or 2
task automatic put_rand_rvc();
  logic [31:0] w;
  logic [31:0] q;
  w = $urandom;
  q = $urandom_range(0, 2);
  put_half({w[15:2], q[1:0]});
endtask

task automatic build_rv32_prog(int n);
  for (int i = 0; i < n; i++) put_rv32();
endtask

task automatic build_rvc_prog(int n_rand);
  // one of each form, c0 reserved last of the c0 group
  half_t forms[$] = '{16'h0a54, 16'h4b58, 16'hc6c4, 16'h8c48,
                      16'h1179, 16'h3f8d, 16'hbfc5, 16'h5541, 16'h7679, 16'h7139,
                      16'h8085, 16'h8489, 16'h8a3d, 16'h8c09, 16'h8da5, 16'h8ec1,
                      16'h8f75, 16'hc115, 16'hfcf1,
                      16'h0592, 16'h4512, 16'h852e, 16'h8082, 16'h952e, 16'h9002,
                      16'h9582, 16'hc22a};
  foreach (forms[i]) put_half(forms[i]);
  for (int i = 0; i < n_rand; i++) put_rand_rvc();
endtask

task automatic build_mixed_prog(int n);
  // a parcel first so the next 32-bit word straddles
  put_rand_rvc();
  put_rv32();
  for (int i = 0; i < n; i++) begin
    if ($urandom_range(0, 1) != 0) put_rv32();
    else put_rand_rvc();
  end
endtask

// expected {pc, instr, flag} stream from start up to stop
task automatic walk_image(input addr_t start, input addr_t stop, output entry_q_t q);
  addr_t       pc;
  half_t       lo;
  logic [32:0] e;
  q  = {};
  pc = start;
  while (pc < stop) begin
    lo = get_half(pc);
    if (lo[1:0] == 2'b11) begin
      q.push_back({pc, get_half(pc + 32'd2), lo, 1'b0});
      pc = pc + 32'd4;
    end else begin
      e = expand_ref(lo);
      q.push_back({pc, e[31:0], e[32]});
      pc = pc + 32'd2;
    end
  end
endtask

`endif

//--- bench/fetch_frontend_tb.sv
//////////////////////////////////////////////////////////////////////
// fetch front end testbench, bus memory model with random latency,
// redirect stimulus, stream checker against the rvc reference
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_frontend_tb;
  import rv_isa_pkg::*;
  import fetch_pkg::*;

  localparam addr_t RESET_PC = 32'h0000_0100;

  typedef logic [64:0] entry_t;
  typedef entry_t entry_q_t[$];

  logic   i_clk = 1'b0;
  logic   i_arst_n;
  logic   i_redirect;
  addr_t  i_redirect_pc;
  logic   i_ready = 1'b0;
  word_t  i_ibus_rdt = 32'd0;
  logic   i_ibus_ack = 1'b0;
  addr_t  o_ibus_adr;
  logic   o_ibus_cyc;
  logic   o_valid;
  instr_t o_instr;
  addr_t  o_pc;
  logic   o_iscomp;

  word_t    mem [0:4095];
  addr_t    wr_ptr;
  entry_q_t exp_q;
  entry_q_t exp_rv32, exp_rvc, exp_mix, exp_jump;
  string    test_name = "reset";
  logic     rand_ready = 1'b0;
  int       wd_limit = 0;
  int       ack_cnt = 0;

  `include "rvc_ref_model.svh"

  fetch_frontend_top #(
    .COMPRESSED (1),
    .RESET_PC   (RESET_PC)
  ) DUT (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .o_ibus_adr    (o_ibus_adr),
    .o_ibus_cyc    (o_ibus_cyc),
    .i_ibus_rdt    (i_ibus_rdt),
    .i_ibus_ack    (i_ibus_ack),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_valid       (o_valid),
    .i_ready       (i_ready),
    .o_instr       (o_instr),
    .o_pc          (o_pc),
    .o_iscomp      (o_iscomp)
  );

  initial begin
    forever #5 i_clk = ~i_clk;
  end

  task automatic fail_mismatch(string field, logic [31:0] exp_v, logic [31:0] act_v);
    $display("Mismatch %s %s expected %h actual %h", test_name, field, exp_v, act_v);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus memory that acks 1 to 4 cycles after the cycle is seen
  //////////////////////////////////////////////////////////////////////
  always @(negedge i_clk) begin
    i_ibus_ack = 1'b0;
    if (o_ibus_cyc) begin
      if (ack_cnt == 0) begin
        ack_cnt = $urandom_range(1, 4);
      end else begin
        ack_cnt = ack_cnt - 1;
        if (ack_cnt == 0) begin
          i_ibus_ack = 1'b1;
          i_ibus_rdt = mem[o_ibus_adr[13:2]];
        end
      end
    end
    // consumer back-pressure drops ready about a third of the time
    i_ready = rand_ready ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  // compare every transfer against the expected stream
  always @(posedge i_clk) begin
    entry_t e;
    if (o_valid && i_ready && !i_redirect && exp_q.size() != 0) begin
      e = exp_q.pop_front();
      assert (o_pc == e[64:33]) else fail_mismatch("pc", e[64:33], o_pc);
      assert (o_instr == e[32:1]) else fail_mismatch("instr", e[32:1], o_instr);
      assert (o_iscomp == e[0]) else fail_mismatch("iscomp", {31'b0, e[0]}, {31'b0, o_iscomp});
    end
  end

  initial begin
    wait (wd_limit != 0);
    repeat (wd_limit + 100) @(posedge i_clk);
    fail_run("watchdog expired, the DUT stopped delivering instructions");
  end

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge i_clk);
  endtask

  task automatic redirect_to(addr_t pc);
    @(negedge i_clk);
    i_redirect    = 1'b1;
    i_redirect_pc = pc;
    @(negedge i_clk);
    i_redirect    = 1'b0;
  endtask

  initial begin
    addr_t end_rv32, end_rvc, end_mix, end_jump;
    void'($urandom(14023));
    i_arst_n      = 1'b0;
    i_redirect    = 1'b0;
    i_redirect_pc = 32'd0;
    for (int i = 0; i < 4096; i++) mem[i] = 32'h5a00_0000 ^ (32'(i) << 2);
    wr_ptr = RESET_PC;
    build_rv32_prog(16);
    end_rv32 = wr_ptr;
    wr_ptr = 32'h1000;
    build_rvc_prog(60);
    end_rvc = wr_ptr;
    wr_ptr = 32'h2000;
    build_mixed_prog(50);
    end_mix = wr_ptr;
    wr_ptr = 32'h3000;
    build_mixed_prog(30);
    end_jump = wr_ptr;
    walk_image(RESET_PC, end_rv32, exp_rv32);
    walk_image(32'h1000, end_rvc, exp_rvc);
    walk_image(32'h2000, end_mix, exp_mix);
    // stream after the odd-halfword redirect
    walk_image(32'h3006, end_jump, exp_jump);
    wd_limit = 40 * (exp_rv32.size() + exp_rvc.size() + 2 * exp_mix.size() + exp_jump.size());

    // reset followed by the rv32-only image at the reset pc
    exp_q = exp_rv32;
    repeat (8) begin
      @(posedge i_clk);
      assert (!o_valid && !o_ibus_cyc) else fail_run("valid or bus cycle active in reset");
    end
    @(negedge i_clk);
    i_arst_n = 1'b1;
    while (!o_ibus_cyc) @(negedge i_clk);
    assert (o_ibus_adr == RESET_PC) else fail_mismatch("first_adr", RESET_PC, o_ibus_adr);
    test_name = "rv32_only";
    wait_drain();

    // the old stream keeps running until the redirect edge
    @(negedge i_clk);
    test_name = "rvc_forms";
    redirect_to(32'h1000);
    exp_q = exp_rvc;
    wait_drain();

    test_name = "mixed";
    redirect_to(32'h2000);
    exp_q = exp_mix;
    wait_drain();

    rand_ready = 1'b1;
    test_name = "mixed_backpressure";
    redirect_to(32'h2000);
    exp_q = exp_mix;
    wait_drain();
    rand_ready = 1'b0;

    // second redirect lands while the first read is still open
    test_name = "odd_redirect";
    redirect_to(32'h3000);
    while (!o_ibus_cyc) @(negedge i_clk);
    exp_q = exp_jump;
    i_redirect    = 1'b1;
    i_redirect_pc = 32'h3006;
    @(negedge i_clk);
    i_redirect    = 1'b0;
    wait_drain();

    @(negedge i_clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+bench
hdl/rv_isa_pkg.sv
hdl/fetch_pkg.sv
hdl/ibus_fetcher.sv
hdl/instr_aligner.sv
hdl/comp_decoder.sv
hdl/instr_out_reg.sv
hdl/fetch_frontend_top.sv
bench/fetch_frontend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the fetch front end testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f \
  --top-module fetch_frontend_tb -o fetch_frontend_sim \
  && ./obj_dir/fetch_frontend_sim \
  || { echo "simulation or build returned an error"; exit 1; }
